/* compile.f */
source/pipe_pkg.sv
source/regfile.sv
source/hazard.sv
source/operand_mux.sv
source/alu.sv
source/data_mem.sv
source/pipe_core.sv
tb/pipe_core_props.sv
tb/pipe_core_tb.sv

/* tb/pipe_core_tb.sv */
`timescale 1ns/1ps

module pipe_core_tb;
	import pipe_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 16;
	localparam int MEM_DEPTH  = 64;
	localparam int N_DIRECTED = 21;
	localparam int N_FILL     = 40;
	localparam int N_STIM     = N_DIRECTED + N_FILL;

	// stalls holds the expected stall cycles, -1 where not checked
	typedef struct packed {
		issue_t ins;
		logic   gap;
		int     stalls;
	} stim_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
	} commit_t;

	logic      clk;
	logic      rst;
	logic      issue_valid;
	issue_t    issue;
	logic      stall;
	logic      commit_valid;
	reg_addr_t commit_rd;
	word_t     commit_data;

	stim_t       stim_tbl [N_STIM];
	word_t       model_regs [32];
	word_t       model_mem [MEM_DEPTH];
	commit_t     expected_q [$];
	logic        held;
	int          stall_cnt;

	pipe_core #(
		.MEM_DEPTH (MEM_DEPTH)
	) pipe_core_i (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.stall        (stall),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic set_entry(input int idx, input op_t op, input int rd, input int rs1,
		input int rs2, input int imm, input int stalls);
		stim_tbl[idx].ins.op  = op;
		stim_tbl[idx].ins.rd  = reg_addr_t'(rd);
		stim_tbl[idx].ins.rs1 = reg_addr_t'(rs1);
		stim_tbl[idx].ins.rs2 = reg_addr_t'(rs2);
		stim_tbl[idx].ins.imm = 16'(imm);
		stim_tbl[idx].gap     = 1'b0;
		stim_tbl[idx].stalls  = stalls;
	endtask

	task automatic build_table();
		op_t op;
		int  rs1;
		int  imm;
		// forwarding at distances one, two and three
		set_entry(0, op_addi, 1, 0, 0, 5, 0);
		set_entry(1, op_addi, 2, 1, 0, 3, 0);
		set_entry(2, op_add, 3, 1, 2, 0, 0);
		set_entry(3, op_sub, 4, 3, 1, 0, 0);
		set_entry(4, op_add, 5, 4, 4, 0, 0);
		set_entry(5, op_or, 6, 2, 3, 0, 0);
		// r0 is never forwarded
		set_entry(6, op_addi, 0, 0, 0, 9, 0);
		set_entry(7, op_add, 7, 0, 0, 0, 0);
		// store of a forwarded value, then load-use at distance one and two
		set_entry(8, op_addi, 1, 0, 0, 100, 0);
		set_entry(9, op_store, 0, 0, 1, 8, 0);
		set_entry(10, op_load, 2, 0, 0, 8, 0);
		set_entry(11, op_add, 3, 2, 1, 0, 2);
		set_entry(12, op_load, 4, 0, 0, 8, 0);
		set_entry(13, op_addi, 5, 0, 0, 1, 0);
		set_entry(14, op_sub, 6, 4, 5, 0, 1);
		// load result as store data
		set_entry(15, op_load, 7, 0, 0, 8, 0);
		set_entry(16, op_store, 0, 0, 7, 12, 2);
		set_entry(17, op_load, 1, 0, 0, 12, 0);
		set_entry(18, op_and, 2, 1, 1, 0, 2);
		set_entry(19, op_addi, 3, 2, 0, 16'hfffc, 0);
		set_entry(20, op_add, 5, 0, 3, 0, 0);
		// random filler, memory ops use r0 as base
		for (int i = N_DIRECTED; i < N_STIM; i++) begin
			op  = op_t'($urandom_range(0, 7));
			rs1 = (op == op_load || op == op_store) ? 0 : $urandom_range(0, 7);
			imm = (op == op_load || op == op_store) ? $urandom_range(0, 63) * 4
				: $urandom_range(0, 65535);
			set_entry(i, op, $urandom_range(0, 7), rs1, $urandom_range(0, 7), imm, -1);
			stim_tbl[i].gap = ($urandom_range(0, 3) == 0);
		end
	endtask

	// in-order reference, run at acceptance
	task automatic execute(input issue_t ins);
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		int    idx;
		a   = model_regs[ins.rs1];
		b   = model_regs[ins.rs2];
		imm = {{16{ins.imm[15]}}, ins.imm};
		idx = int'((a + imm) >> 2) % MEM_DEPTH;
		res = '0;
		case (ins.op)
			op_add:   res = a + b;
			op_sub:   res = a - b;
			op_and:   res = a & b;
			op_or:    res = a | b;
			op_xor:   res = a ^ b;
			op_addi:  res = a + imm;
			op_load:  res = model_mem[idx];
			op_store: model_mem[idx] = b;
			default:  res = '0;
		endcase
		if (ins.op != op_store) begin
			expected_q.push_back('{rd: ins.rd, data: res});
			if (ins.rd != '0)
				model_regs[ins.rd] = res;
		end
	endtask

	// commit monitor
	initial begin
		commit_t exp_c;
		@(negedge rst);
		forever begin
			@(negedge clk);
			if (commit_valid) begin
				if (expected_q.size() == 0) begin
					$display("unexpected commit to r%0d at %0t ns with nothing outstanding",
						commit_rd, $time);
					$display("TEST RESULT: FAIL");
					$fatal(1, "unexpected commit");
				end else begin
					exp_c = expected_q.pop_front();
					check("commit_rd", word_t'(commit_rd), word_t'(exp_c.rd));
					check("commit_data", commit_data, exp_c.data);
				end
			end
		end
	end

	initial begin
		#((N_STIM * 4 + RST_CYCLES + 20) * CLK_PERIOD);
		$display("watchdog expired at %0t ns, the pipeline stopped committing", $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'hbacf));
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue       = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			model_mem[i] = '0;
		build_table();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("stall after reset", word_t'(stall), '0);
		check("commit_valid after reset", word_t'(commit_valid), '0);
		@(posedge clk);
		for (int i = 0; i < N_STIM; i++) begin
			if (stim_tbl[i].gap) begin
				issue_valid <= 1'b0;
				@(posedge clk);
			end
			issue_valid <= 1'b1;
			issue       <= stim_tbl[i].ins;
			// hold the entry while stalled
			stall_cnt = 0;
			do begin
				@(negedge clk);
				held = stall;
				if (held)
					stall_cnt++;
				@(posedge clk);
			end while (held);
			if (stim_tbl[i].stalls >= 0)
				check($sformatf("stall cycles of entry %0d", i), word_t'(stall_cnt),
					word_t'(stim_tbl[i].stalls));
			execute(stim_tbl[i].ins);
		end
		issue_valid <= 1'b0;
		repeat (5) @(posedge clk);
		if (expected_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("%0d expected commits never arrived", expected_q.size());
			$display("TEST RESULT: FAIL");
			$fatal(1, "missing commits");
		end
	end

endmodule

/* tb/pipe_core_props.sv */
`timescale 1ns/1ps

module pipe_core_props (
	input logic                 clk,
	input logic                 rst,
	input logic                 issue_valid,
	input pipe_pkg::issue_t     issue,
	input logic                 stall,
	input logic                 commit_valid,
	input pipe_pkg::reg_addr_t  commit_rd,
	input pipe_pkg::fwd_sel_t   rs1val_cont,
	input pipe_pkg::fwd_sel_t   rs2val_cont,
	input pipe_pkg::stage_ctl_t ex_ctl,
	input pipe_pkg::stage_ctl_t mem_ctl,
	input pipe_pkg::stage_ctl_t wb_ctl
);
	import pipe_pkg::*;

	// a forwarded source never names r0
	function automatic logic fwd_rd_nonzero(input fwd_sel_t sel, input stage_ctl_t ex,
		input stage_ctl_t mem, input stage_ctl_t wb);
		case (sel)
			fwd_ex_alu:  return ex.rd != '0;
			fwd_mem_alu: return mem.rd != '0;
			fwd_wb_alu,
			fwd_wb_mem:  return wb.rd != '0;
			default:     return 1'b1;
		endcase
	endfunction

	after_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !stall && !commit_valid)
		else $error("stall or commit_valid high right after reset");

	// three edges from acceptance to commit
	commit_latency: assert property (@(posedge clk) disable iff (rst)
		issue_valid && !stall && (issue.op != op_store)
		|-> ##3 (commit_valid && (commit_rd == $past(issue.rd, 3))))
		else $error("accepted instruction did not commit three edges later");

	fwd_rs1_nonzero: assert property (@(posedge clk) disable iff (rst)
		fwd_rd_nonzero(rs1val_cont, ex_ctl, mem_ctl, wb_ctl))
		else $error("rs1 forwarded from a stage writing r0");

	fwd_rs2_nonzero: assert property (@(posedge clk) disable iff (rst)
		fwd_rd_nonzero(rs2val_cont, ex_ctl, mem_ctl, wb_ctl))
		else $error("rs2 forwarded from a stage writing r0");

	stall_max_two: assert property (@(posedge clk) disable iff (rst)
		stall && $past(stall) |=> !stall)
		else $error("stall high for more than two cycles");

endmodule

bind pipe_core pipe_core_props props_i (
	.clk          (clk),
	.rst          (rst),
	.issue_valid  (issue_valid),
	.issue        (issue),
	.stall        (stall),
	.commit_valid (commit_valid),
	.commit_rd    (commit_rd),
	.rs1val_cont  (rs1val_cont),
	.rs2val_cont  (rs2val_cont),
	.ex_ctl       (ex_ctl),
	.mem_ctl      (mem_ctl),
	.wb_ctl       (wb_ctl)
);

/* source/pipe_core.sv */
`timescale 1ns/1ps

module pipe_core #(
	parameter int MEM_DEPTH = 64
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue_valid,
	input  pipe_pkg::issue_t    issue,
	output logic                stall,
	output logic                commit_valid,
	output pipe_pkg::reg_addr_t commit_rd,
	output pipe_pkg::word_t     commit_data
);
	import pipe_pkg::*;

	// ID stage
	logic       id_regwr;
	wbsel_t     id_wbsel;
	logic       id_uses_rs2;
	reg_addr_t  id_rs1;
	reg_addr_t  id_rs2;
	word_t      rf_a;
	word_t      rf_b;
	fwd_sel_t   rs1val_cont;
	fwd_sel_t   rs2val_cont;
	word_t      id_op_a;
	word_t      id_op_b;
	stage_ctl_t id_ctl;

	// EX stage
	stage_ctl_t ex_ctl;
	op_t        ex_op;
	word_t      ex_a;
	word_t      ex_b;
	word_t      ex_imm;
	word_t      ex_alu_res;

	// MEM stage
	stage_ctl_t mem_ctl;
	logic       mem_store;
	word_t      mem_alu_res;
	word_t      mem_store_data;

	// WB stage
	stage_ctl_t wb_ctl;
	word_t      wb_alu_res;
	word_t      wb_mem_data;
	word_t      wb_value;

	// decode of write-back behavior
	always_comb begin
		id_regwr    = 1'b1;
		id_wbsel    = 1'b0;
		id_uses_rs2 = 1'b1;
		case (issue.op)
			op_addi: id_uses_rs2 = 1'b0;
			op_load: begin
				id_wbsel    = 1'b1;
				id_uses_rs2 = 1'b0;
			end
			op_store: id_regwr = 1'b0;
			default: id_regwr = 1'b1;
		endcase
	end

	// unused or idle sources read r0 so they never raise a hazard
	assign id_rs1 = issue_valid ? issue.rs1 : '0;
	assign id_rs2 = (issue_valid && id_uses_rs2) ? issue.rs2 : '0;

	// bubble when stalled
	assign id_ctl = '{valid: issue_valid && !stall, regwr: id_regwr,
		wbsel: id_wbsel, rd: issue.rd};

	regfile regfile_i (
		.clk       (clk),
		.rst       (rst),
		.rd_addr_a (id_rs1),
		.rd_addr_b (id_rs2),
		.rd_data_a (rf_a),
		.rd_data_b (rf_b),
		.wr_en     (commit_valid),
		.wr_addr   (wb_ctl.rd),
		.wr_data   (wb_value)
	);

	hazard hazard_i (
		.id_rs1      (id_rs1),
		.id_rs2      (id_rs2),
		.ex_ctl      (ex_ctl),
		.mem_ctl     (mem_ctl),
		.wb_ctl      (wb_ctl),
		.rs1val_cont (rs1val_cont),
		.rs2val_cont (rs2val_cont),
		.stall       (stall)
	);

	operand_mux rs1_mux_i (
		.sel     (rs1val_cont),
		.rf_val  (rf_a),
		.ex_alu  (ex_alu_res),
		.mem_alu (mem_alu_res),
		.wb_alu  (wb_alu_res),
		.wb_mem  (wb_mem_data),
		.operand (id_op_a)
	);

	operand_mux rs2_mux_i (
		.sel     (rs2val_cont),
		.rf_val  (rf_b),
		.ex_alu  (ex_alu_res),
		.mem_alu (mem_alu_res),
		.wb_alu  (wb_alu_res),
		.wb_mem  (wb_mem_data),
		.operand (id_op_b)
	);

	alu alu_i (
		.op     (ex_op),
		.a      (ex_a),
		.b      (ex_b),
		.imm    (ex_imm),
		.result (ex_alu_res)
	);

	data_mem #(
		.MEM_DEPTH (MEM_DEPTH)
	) data_mem_i (
		.clk     (clk),
		.rst     (rst),
		.addr    (mem_alu_res),
		.wr_en   (mem_store),
		.wr_data (mem_store_data),
		.rd_data (wb_mem_data)
	);

	// stage control
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_ctl    <= '0;
			mem_ctl   <= '0;
			wb_ctl    <= '0;
			mem_store <= 1'b0;
		end else begin
			ex_ctl    <= id_ctl;
			mem_ctl   <= ex_ctl;
			wb_ctl    <= mem_ctl;
			mem_store <= ex_ctl.valid && (ex_op == op_store);
		end
	end

	// stage payload
	always_ff @(posedge clk) begin
		ex_op          <= issue.op;
		ex_a           <= id_op_a;
		ex_b           <= id_op_b;
		ex_imm         <= {{16{issue.imm[15]}}, issue.imm};
		mem_alu_res    <= ex_alu_res;
		// rs2 of a store is the data to write
		mem_store_data <= ex_b;
		wb_alu_res     <= mem_alu_res;
	end

	assign wb_value     = wb_ctl.wbsel ? wb_mem_data : wb_alu_res;
	assign commit_valid = wb_ctl.valid && wb_ctl.regwr;
	assign commit_rd    = wb_ctl.rd;
	assign commit_data  = wb_value;

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
	parameter int MEM_DEPTH = 64
) (
	input  logic            clk,
	input  logic            rst,
	input  pipe_pkg::word_t addr,
	input  logic            wr_en,
	input  pipe_pkg::word_t wr_data,
	output pipe_pkg::word_t rd_data
);
	import pipe_pkg::*;

	localparam int IDX_W = $clog2(MEM_DEPTH);

	word_t             mem [MEM_DEPTH];
	logic [IDX_W-1:0]  idx;

	// drop the byte offset, wrap at the memory size
	assign idx = IDX_W'((addr >> 2) % MEM_DEPTH);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
			rd_data <= '0;
		end else begin
			// read returns the word before this edge's write
			rd_data <= mem[idx];
			if (wr_en)
				mem[idx] <= wr_data;
		end
	end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	input  pipe_pkg::op_t   op,
	input  pipe_pkg::word_t a,
	input  pipe_pkg::word_t b,
	input  pipe_pkg::word_t imm,
	output pipe_pkg::word_t result
);
	import pipe_pkg::*;

	always_comb begin
		case (op)
			op_add: result = a + b;
			op_sub: result = a - b;
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			// immediate add and load/store address
			op_addi,
			op_load,
			op_store: result = a + imm;
			default: result = '0;
		endcase
	end

endmodule

/* source/operand_mux.sv */
`timescale 1ns/1ps

module operand_mux (
	input  pipe_pkg::fwd_sel_t sel,
	input  pipe_pkg::word_t    rf_val,
	input  pipe_pkg::word_t    ex_alu,
	input  pipe_pkg::word_t    mem_alu,
	input  pipe_pkg::word_t    wb_alu,
	input  pipe_pkg::word_t    wb_mem,
	output pipe_pkg::word_t    operand
);
	import pipe_pkg::*;

	always_comb begin
		case (sel)
			fwd_ex_alu:  operand = ex_alu;
			fwd_mem_alu: operand = mem_alu;
			fwd_wb_alu:  operand = wb_alu;
			fwd_wb_mem:  operand = wb_mem;
			// fwd_rf and the unused codes
			default:     operand = rf_val;
		endcase
	end

endmodule

/* source/hazard.sv */
`timescale 1ns/1ps

module hazard (
	input  pipe_pkg::reg_addr_t  id_rs1,
	input  pipe_pkg::reg_addr_t  id_rs2,
	input  pipe_pkg::stage_ctl_t ex_ctl,
	input  pipe_pkg::stage_ctl_t mem_ctl,
	input  pipe_pkg::stage_ctl_t wb_ctl,
	output pipe_pkg::fwd_sel_t   rs1val_cont,
	output pipe_pkg::fwd_sel_t   rs2val_cont,
	output logic                 stall
);
	import pipe_pkg::*;

	logic rs1_wait;
	logic rs2_wait;

	// a stage can only match if it really writes a nonzero register
	function automatic logic hits(input stage_ctl_t s, input reg_addr_t rs);
		return s.valid && s.regwr && (s.rd != '0) && (s.rd == rs);
	endfunction

	// nearest stage first, per operand
	function automatic void resolve(
		input  reg_addr_t  rs,
		input  stage_ctl_t ex,
		input  stage_ctl_t mem,
		input  stage_ctl_t wb,
		output fwd_sel_t   sel,
		output logic       wait_ld
	);
		sel     = fwd_rf;
		wait_ld = 1'b0;
		if (hits(ex, rs)) begin
			// load still in EX, data two cycles away
			if (ex.wbsel)
				wait_ld = 1'b1;
			else
				sel = fwd_ex_alu;
		end else if (hits(mem, rs)) begin
			// load data only shows up in WB
			if (mem.wbsel)
				wait_ld = 1'b1;
			else
				sel = fwd_mem_alu;
		end else if (hits(wb, rs)) begin
			sel = wb.wbsel ? fwd_wb_mem : fwd_wb_alu;
		end
	endfunction

	always_comb begin
		resolve(id_rs1, ex_ctl, mem_ctl, wb_ctl, rs1val_cont, rs1_wait);
		resolve(id_rs2, ex_ctl, mem_ctl, wb_ctl, rs2val_cont, rs2_wait);
	end

	assign stall = rs1_wait | rs2_wait;

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic              clk,
	input  logic              rst,
	input  pipe_pkg::reg_addr_t rd_addr_a,
	input  pipe_pkg::reg_addr_t rd_addr_b,
	output pipe_pkg::word_t   rd_data_a,
	output pipe_pkg::word_t   rd_data_b,
	input  logic              wr_en,
	input  pipe_pkg::reg_addr_t wr_addr,
	input  pipe_pkg::word_t   wr_data
);
	import pipe_pkg::*;

	word_t regs [32];

	// r0 always reads as zero
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

	// data and register index widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// write-back source, 0 = alu result, 1 = memory data
	typedef logic wbsel_t;

	// operand source code
	// bits [2:1] pick the stage, bit 0 picks alu result or memory data
	typedef logic [2:0] fwd_sel_t;

	localparam fwd_sel_t fwd_rf      = 3'b000;
	localparam fwd_sel_t fwd_ex_alu  = 3'b010;
	localparam fwd_sel_t fwd_mem_alu = 3'b100;
	localparam fwd_sel_t fwd_wb_alu  = 3'b110;
	localparam fwd_sel_t fwd_wb_mem  = 3'b111;

	typedef enum logic [2:0] {
		op_add, op_sub, op_and, op_or, op_xor, op_addi, op_load, op_store
	} op_t;

	// what a stage will write back
	typedef struct packed {
		logic      valid;
		logic      regwr;
		wbsel_t    wbsel;
		reg_addr_t rd;
	} stage_ctl_t;

	// decoded instruction at the issue port
	typedef struct packed {
		op_t                op;
		reg_addr_t          rd;
		reg_addr_t          rs1;
		reg_addr_t          rs2;
		logic signed [15:0] imm;
	} issue_t;

endpackage
